//--- logic/decode_ctrl.sv
// Instruction decode and immediate generation
module decode_ctrl (
  input  logic [31:0] pc,
  input  logic [31:0] instr,
  output logic [4:0]  rs1_addr,
  output logic [4:0]  rs2_addr,
  input  logic [31:0] rs1_val,
  input  logic [31:0] rs2_val,
  exec_if.decode      ex
);

  localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

  rv_pkg::instr_u iw;
  logic [31:0]    imm_i;
  logic [31:0]    imm_b;
  logic [31:0]    imm_u;
  logic [31:0]    imm_j;
  logic [6:0]     opcode;
  logic           we;

  assign iw     = instr;
  assign opcode = iw.r_fmt.opcode;

  assign imm_i = {{20{iw.i_fmt.imm[11]}}, iw.i_fmt.imm};
  assign imm_b = {{20{iw.b_fmt.imm_12}}, iw.b_fmt.imm_11, iw.b_fmt.imm_10_5,
                  iw.b_fmt.imm_4_1, 1'b0};
  assign imm_u = {iw.u_fmt.imm_31_12, 12'b0};
  assign imm_j = {{12{iw.j_fmt.imm_20}}, iw.j_fmt.imm_19_12, iw.j_fmt.imm_11,
                  iw.j_fmt.imm_10_1, 1'b0};

  // U and J have no rs1, only R and B read rs2
  assign rs1_addr = (opcode == rv_pkg::OPC_LUI || opcode == rv_pkg::OPC_JAL) ?
                    5'd0 : iw.r_fmt.rs1;
  assign rs2_addr = (opcode == rv_pkg::OPC_OP || opcode == rv_pkg::OPC_BRANCH) ?
                    iw.r_fmt.rs2 : 5'd0;

  assign ex.pc      = pc;
  assign ex.rs1_val = rs1_val;
  assign ex.rs2_val = rs2_val;
  assign ex.rd_addr = iw.r_fmt.rd;
  assign ex.rd_we   = we && (iw.r_fmt.rd != 5'd0); // x0 never written

  always_comb begin
    ex.imm       = '0;
    ex.alu_op    = rv_pkg::ALU_ADD;
    ex.use_imm   = 1'b0;
    ex.is_branch = 1'b0;
    ex.branch_ne = 1'b0;
    ex.is_jal    = 1'b0;
    ex.is_halt   = 1'b0;
    we           = 1'b0; // Anything unmatched retires as a no-op
    case (opcode)
      rv_pkg::OPC_LUI: begin
        ex.imm     = imm_u;
        ex.use_imm = 1'b1;
        ex.alu_op  = rv_pkg::ALU_PASSB;
        we         = 1'b1;
      end
      rv_pkg::OPC_OPIMM: begin
        ex.imm     = imm_i;
        ex.use_imm = 1'b1;
        we         = 1'b1;
        case (iw.i_fmt.funct3)
          3'b000:  ex.alu_op = rv_pkg::ALU_ADD;
          3'b010:  ex.alu_op = rv_pkg::ALU_SLT;
          3'b100:  ex.alu_op = rv_pkg::ALU_XOR;
          3'b110:  ex.alu_op = rv_pkg::ALU_OR;
          3'b111:  ex.alu_op = rv_pkg::ALU_AND;
          default: we = 1'b0; // Shifts and SLTIU not supported
        endcase
      end
      rv_pkg::OPC_OP: begin
        we = 1'b1;
        case ({iw.r_fmt.funct7, iw.r_fmt.funct3})
          10'b0000000_000: ex.alu_op = rv_pkg::ALU_ADD;
          10'b0100000_000: ex.alu_op = rv_pkg::ALU_SUB;
          10'b0000000_010: ex.alu_op = rv_pkg::ALU_SLT;
          10'b0000000_100: ex.alu_op = rv_pkg::ALU_XOR;
          10'b0000000_110: ex.alu_op = rv_pkg::ALU_OR;
          10'b0000000_111: ex.alu_op = rv_pkg::ALU_AND;
          default:         we = 1'b0;
        endcase
      end
      rv_pkg::OPC_BRANCH: begin
        ex.imm       = imm_b;
        ex.is_branch = (iw.b_fmt.funct3 == 3'b000) || (iw.b_fmt.funct3 == 3'b001);
        ex.branch_ne = iw.b_fmt.funct3[0];
      end
      rv_pkg::OPC_JAL: begin
        ex.imm    = imm_j;
        ex.is_jal = 1'b1;
        we        = 1'b1; // Link value chosen in execute
      end
      rv_pkg::OPC_SYSTEM: ex.is_halt = (instr == EBREAK_WORD);
      default: ;
    endcase
  end

endmodule

//--- logic/exec_if.sv
// Decode to execute bundle
interface exec_if;

  logic [31:0] pc;        // Address of the instruction in decode
  logic [31:0] rs1_val;
  logic [31:0] rs2_val;
  logic [31:0] imm;       // Sign-extended, format already resolved
  logic [2:0]  alu_op;
  logic        use_imm;   // ALU operand B from imm
  logic        is_branch;
  logic        branch_ne; // BNE, inverts the equality test
  logic        is_jal;
  logic [4:0]  rd_addr;
  logic        rd_we;     // Already low for rd zero
  logic        is_halt;   // EBREAK

  modport decode (
    output pc, rs1_val, rs2_val, imm, alu_op, use_imm,
           is_branch, branch_ne, is_jal, rd_addr, rd_we, is_halt
  );

  modport execute (
    input pc, rs1_val, rs2_val, imm, alu_op, use_imm,
          is_branch, branch_ne, is_jal, rd_addr, rd_we, is_halt
  );

endinterface

//--- logic/execute_unit.sv
// ALU, branch resolve and writeback
module execute_unit (
  input  logic        step,
  exec_if.execute     ex,
  output logic        wb_en,
  output logic [4:0]  wb_addr,
  output logic [31:0] wb_data,
  output logic        sel_target,
  output logic [31:0] target,
  output logic        halt_req
);

  logic [31:0] op_b;
  logic [31:0] alu_res;
  logic        taken;

  assign op_b = ex.use_imm ? ex.imm : ex.rs2_val;

  always_comb begin
    case (ex.alu_op)
      rv_pkg::ALU_ADD:   alu_res = ex.rs1_val + op_b;
      rv_pkg::ALU_SUB:   alu_res = ex.rs1_val - op_b;
      rv_pkg::ALU_AND:   alu_res = ex.rs1_val & op_b;
      rv_pkg::ALU_OR:    alu_res = ex.rs1_val | op_b;
      rv_pkg::ALU_XOR:   alu_res = ex.rs1_val ^ op_b;
      rv_pkg::ALU_SLT:   alu_res = {31'd0, $signed(ex.rs1_val) < $signed(op_b)};
      rv_pkg::ALU_PASSB: alu_res = op_b; // LUI
      default:           alu_res = '0;
    endcase
  end

  // BEQ or BNE depending on the inversion
  assign taken = ex.is_branch && ((ex.rs1_val == ex.rs2_val) ^ ex.branch_ne);

  // EBREAK points the PC back at itself so it stays put
  assign sel_target = taken || ex.is_jal || ex.is_halt;
  assign target     = ex.is_halt ? ex.pc : ex.pc + ex.imm;

  assign wb_en   = step && ex.rd_we; // Nothing retires while stopped
  assign wb_addr = ex.rd_addr;
  assign wb_data = ex.is_jal ? ex.pc + 32'd4 : alu_res; // Link address

  assign halt_req = step && ex.is_halt;

endmodule

//--- logic/host_axil.sv
// AXI4-Lite host port and run control
module host_axil #(
  parameter int IMEM_WORDS = 1024
) (
  input  logic        clk,
  input  logic        rst,
  input  logic [15:0] awaddr,
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] wdata,
  input  logic        wvalid,
  output logic        wready,
  output logic [1:0]  bresp,
  output logic        bvalid,
  input  logic        bready,
  input  logic [15:0] araddr,
  input  logic        arvalid,
  output logic        arready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  output logic        rvalid,
  input  logic        rready,
  output logic        imem_we,
  output logic [9:0]  imem_addr,
  output logic [31:0] imem_data,
  output logic        restart,
  output logic        step,
  input  logic        halt_req,
  input  logic [31:0] pc,
  output logic [4:0]  dbg_addr,
  input  logic [31:0] dbg_data
);

  localparam logic [15:0] IMEM_BYTES = 16'(IMEM_WORDS * 4);

  logic        wr_hs;   // Address and data taken this cycle
  logic        rd_hs;
  logic        ctrl_wr;
  logic        run;
  logic        halted;
  logic [31:0] rd_sel;

  assign wr_hs   = awready && awvalid && wvalid;
  assign rd_hs   = arready && arvalid;
  assign ctrl_wr = wr_hs && (awaddr == rv_pkg::ADDR_CTRL);
  assign wready  = awready; // AW and W always accepted together
  assign bresp   = 2'b00;   // OKAY, unmapped writes dropped silently
  assign rresp   = 2'b00;

  assign imem_we   = wr_hs && (awaddr < IMEM_BYTES);
  assign imem_addr = awaddr[11:2];
  assign imem_data = wdata;
  assign restart   = ctrl_wr && wdata[0];
  assign step      = run && !halted;
  assign dbg_addr  = araddr[6:2];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      awready <= 1'b0;
      bvalid  <= 1'b0;
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      awready <= awvalid && wvalid && !bvalid && !awready; // One-cycle pulse
      arready <= arvalid && !rvalid && !arready;
      if (wr_hs) bvalid <= 1'b1;
      else if (bready) bvalid <= 1'b0;
      if (rd_hs) rvalid <= 1'b1;
      else if (rready) rvalid <= 1'b0;
    end
  end

  // Start clears halted, a later halt sets it
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      run    <= 1'b0;
      halted <= 1'b0;
    end else if (ctrl_wr) begin
      run <= wdata[0];
      if (wdata[0]) halted <= 1'b0;
    end else if (halt_req) begin
      halted <= 1'b1;
    end
  end

  always_comb begin
    if (araddr == rv_pkg::ADDR_CTRL) rd_sel = {31'd0, run};
    else if (araddr == rv_pkg::ADDR_STATUS) rd_sel = {30'd0, run, halted};
    else if (araddr == rv_pkg::ADDR_PC) rd_sel = pc;
    else if (araddr[15:7] == rv_pkg::ADDR_REGS[15:7] && araddr[1:0] == 2'b00)
      rd_sel = dbg_data; // Register window, x0..x31
    else rd_sel = '0;
  end

  always_ff @(posedge clk) begin
    if (rd_hs) rdata <= rd_sel; // Held while rvalid waits
  end

endmodule

//--- logic/pc_fetch.sv
// Program counter and instruction fetch
module pc_fetch #(
  parameter int IMEM_WORDS = 1024
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        step,       // Retire on this edge
  input  logic        restart,    // Host start, back to zero
  input  logic        sel_target, // Branch taken, jump or halt
  input  logic [31:0] target,
  input  logic        imem_we,    // Host load port
  input  logic [9:0]  imem_addr,  // Word index
  input  logic [31:0] imem_data,
  output logic [31:0] pc,
  output logic [31:0] instr
);

  localparam int AW = $clog2(IMEM_WORDS); // Word index width

  logic [31:0] imem [IMEM_WORDS];
  logic [31:0] pc_plus4;

  assign pc_plus4 = pc + 32'd4;

  // Restart beats step if both show up together
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc <= '0;
    end else if (restart) begin
      pc <= '0;
    end else if (step) begin
      pc <= sel_target ? target : pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (imem_we) begin
      imem[imem_addr[AW-1:0]] <= imem_data; // Only the host writes
    end
  end

  // Asynchronous read so the whole instruction finishes in one clock
  assign instr = imem[pc[AW+1:2]];

endmodule

//--- logic/reg_file.sv
// Integer register file
module reg_file (
  input  logic        clk,
  input  logic        rst,
  input  logic [4:0]  rs1_addr,
  input  logic [4:0]  rs2_addr,
  output logic [31:0] rs1_val,
  output logic [31:0] rs2_val,
  input  logic        wb_en,
  input  logic [4:0]  wb_addr,
  input  logic [31:0] wb_data,
  input  logic [4:0]  dbg_addr, // Host readback
  output logic [31:0] dbg_data
);

  logic [31:0] regs [1:31]; // No storage behind x0

  function automatic logic [31:0] read_port(input logic [4:0] addr);
    read_port = (addr == 5'd0) ? 32'd0 : regs[addr];
  endfunction

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) regs[i] <= '0;
    end else if (wb_en && wb_addr != 5'd0) begin
      regs[wb_addr] <= wb_data;
    end
  end

  assign rs1_val  = read_port(rs1_addr);
  assign rs2_val  = read_port(rs2_addr);
  assign dbg_data = read_port(dbg_addr);

endmodule

//--- logic/rv_core_top.sv
// Single-cycle RV32I core top level
module rv_core_top #(
  parameter int IMEM_WORDS = 1024 // Power of two, 1024 at most
) (
  input  logic        clk,
  input  logic        rst,
  input  logic [15:0] awaddr,
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] wdata,
  input  logic        wvalid,
  output logic        wready,
  output logic [1:0]  bresp,
  output logic        bvalid,
  input  logic        bready,
  input  logic [15:0] araddr,
  input  logic        arvalid,
  output logic        arready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  output logic        rvalid,
  input  logic        rready
);

  logic [31:0] pc;
  logic [31:0] instr;
  logic [4:0]  rs1_addr;
  logic [4:0]  rs2_addr;
  logic [31:0] rs1_val;
  logic [31:0] rs2_val;
  logic        wb_en;
  logic [4:0]  wb_addr;
  logic [31:0] wb_data;
  logic        sel_target;
  logic [31:0] target;
  logic        halt_req;
  logic        step;
  logic        restart;
  logic        imem_we;
  logic [9:0]  imem_addr;
  logic [31:0] imem_data;
  logic [4:0]  dbg_addr;
  logic [31:0] dbg_data;

  exec_if ex_bus ();

  pc_fetch #(.IMEM_WORDS(IMEM_WORDS)) i_pc_fetch (
    .clk, .rst, .step, .restart, .sel_target, .target,
    .imem_we, .imem_addr, .imem_data, .pc, .instr
  );

  decode_ctrl i_decode_ctrl (
    .pc, .instr, .rs1_addr, .rs2_addr, .rs1_val, .rs2_val, .ex(ex_bus)
  );

  reg_file i_reg_file (
    .clk, .rst, .rs1_addr, .rs2_addr, .rs1_val, .rs2_val,
    .wb_en, .wb_addr, .wb_data, .dbg_addr, .dbg_data
  );

  execute_unit i_execute_unit (
    .step, .ex(ex_bus), .wb_en, .wb_addr, .wb_data, .sel_target, .target, .halt_req
  );

  host_axil #(.IMEM_WORDS(IMEM_WORDS)) i_host_axil (
    .clk, .rst, .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
    .bresp, .bvalid, .bready, .araddr, .arvalid, .arready, .rdata, .rresp,
    .rvalid, .rready, .imem_we, .imem_addr, .imem_data, .restart, .step,
    .halt_req, .pc, .dbg_addr, .dbg_data
  );

endmodule

//--- logic/rv_pkg.sv
// RV32I core shared definitions
package rv_pkg;

  localparam logic [6:0] OPC_LUI    = 7'b0110111; // Load upper immediate
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011; // Register-immediate ALU
  localparam logic [6:0] OPC_OP     = 7'b0110011; // Register-register ALU
  localparam logic [6:0] OPC_BRANCH = 7'b1100011; // Conditional branches
  localparam logic [6:0] OPC_JAL    = 7'b1101111; // Jump and link
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011; // EBREAK lives here

  localparam logic [2:0] ALU_ADD   = 3'd0;
  localparam logic [2:0] ALU_SUB   = 3'd1;
  localparam logic [2:0] ALU_AND   = 3'd2;
  localparam logic [2:0] ALU_OR    = 3'd3;
  localparam logic [2:0] ALU_XOR   = 3'd4;
  localparam logic [2:0] ALU_SLT   = 3'd5; // Signed compare
  localparam logic [2:0] ALU_PASSB = 3'd6; // Second operand straight through

  localparam logic [15:0] ADDR_CTRL   = 16'h1000; // Bit 0 is run
  localparam logic [15:0] ADDR_STATUS = 16'h1004; // Halted, run
  localparam logic [15:0] ADDR_PC     = 16'h1008;
  localparam logic [15:0] ADDR_REGS   = 16'h1100; // x0..x31, word stride

  // One instruction word, five ways to look at it
  typedef union packed {
    struct packed {
      logic [6:0] funct7; logic [4:0] rs2; logic [4:0] rs1;
      logic [2:0] funct3; logic [4:0] rd;  logic [6:0] opcode;
    } r_fmt;
    struct packed {
      logic [11:0] imm; logic [4:0] rs1; logic [2:0] funct3;
      logic [4:0]  rd;  logic [6:0] opcode;
    } i_fmt;
    struct packed {
      logic imm_12; logic [5:0] imm_10_5; logic [4:0] rs2; logic [4:0] rs1;
      logic [2:0] funct3; logic [3:0] imm_4_1; logic imm_11; logic [6:0] opcode;
    } b_fmt;
    struct packed {
      logic [19:0] imm_31_12; logic [4:0] rd; logic [6:0] opcode;
    } u_fmt;
    struct packed {
      logic imm_20; logic [9:0] imm_10_1; logic imm_11; logic [7:0] imm_19_12;
      logic [4:0] rd; logic [6:0] opcode;
    } j_fmt;
  } instr_u;

endpackage

//--- run.sh
#!/bin/sh
# Build and run the RV32I core testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_rv_core \
  -f vlog.f -o tb_rv_core > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_rv_core > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -qF "*** TEST FAILED ***" "$LOG"; then
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi
exit 0

//--- test/rv_core_props.sv
// Bus and core protocol assertions
module rv_core_props (
  input logic        clk,
  input logic        rst,
  input logic        bvalid,
  input logic        bready,
  input logic        rvalid,
  input logic        rready,
  input logic [31:0] rdata,
  input logic [31:0] pc,
  input logic        restart,
  input logic        halted
);

  a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
    bvalid && !bready |=> bvalid) else $error("bvalid dropped before bready");

  a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
    rvalid && !rready |=> rvalid) else $error("rvalid dropped before rready");

  a_rdata_stable: assert property (@(posedge clk) disable iff (rst)
    rvalid && !rready |=> $stable(rdata)) else $error("rdata changed while waiting");

  a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
    pc[1:0] == 2'b00) else $error("PC not word aligned");

  a_pc_held_halted: assert property (@(posedge clk) disable iff (rst)
    halted && !restart |=> $stable(pc)) else $error("PC moved while halted");

endmodule

bind rv_core_top rv_core_props i_rv_core_props (
  .clk, .rst, .bvalid, .bready, .rvalid, .rready, .rdata, .pc, .restart,
  .halted(i_host_axil.halted)
);

//--- test/tb_clock.sv
// Testbench clock and reset
module tb_clock #(
  parameter int PERIOD       = 4,
  parameter int RESET_CYCLES = 3
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk; // Free-running
  end

  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst = 1'b0; // Released just after an edge
  end

endmodule

//--- test/tb_rv_core.sv
// RV32I core directed testbench
module tb_rv_core;

  localparam logic [15:0] ADDR_CTRL   = 16'h1000; // Host map
  localparam logic [15:0] ADDR_STATUS = 16'h1004;
  localparam logic [15:0] ADDR_PC     = 16'h1008;
  localparam logic [15:0] ADDR_REGS   = 16'h1100;
  localparam logic [31:0] EBREAK      = 32'h0010_0073;
  localparam logic [2:0]  F_ADD = 3'b000; // funct3 codes
  localparam logic [2:0]  F_SLT = 3'b010;
  localparam logic [2:0]  F_XOR = 3'b100;
  localparam logic [2:0]  F_OR  = 3'b110;
  localparam logic [2:0]  F_AND = 3'b111;
  localparam logic [6:0]  F7_SUB = 7'b0100000;
  localparam int WATCHDOG_CYCLES = 4000; // Sum of bounded test lengths

  logic        clk;
  logic        rst;
  logic [15:0] awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [15:0] araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;

  logic [31:0] prog [0:63];   // Program under test
  logic [31:0] m_regs [0:31]; // Reference model state that persists like the DUT
  logic [31:0] m_pc;
  logic [31:0] lfsr_state = 32'h905087dc;

  tb_clock #(.PERIOD(4), .RESET_CYCLES(3)) i_tb_clock (.clk, .rst);

  rv_core_top #(.IMEM_WORDS(1024)) i_rv_core_top (
    .clk, .rst, .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
    .bresp, .bvalid, .bready, .araddr, .arvalid, .arready, .rdata, .rresp,
    .rvalid, .rready
  );

  task automatic fail_stop();
    $display("*** TEST FAILED ***");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL time=%0t %s got=%h expected=%h", $time, name, got, exp);
      fail_stop();
    end
  endtask

  // Fibonacci taps 32, 22, 2, 1; one step per bit handed out
  function automatic logic [31:0] take_bits(input int n);
    logic fb;
    take_bits = '0;
    for (int k = 0; k < n; k++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      take_bits = {take_bits[30:0], fb};
    end
  endfunction

  function automatic logic [31:0] imm_op(input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [4:0] rs1, input logic [11:0] imm);
    imm_op = {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] reg_op(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
    reg_op = {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] lui_op(input logic [4:0] rd, input logic [19:0] imm);
    lui_op = {imm, rd, 7'b0110111};
  endfunction

  function automatic logic [31:0] branch_op(input logic [2:0] f3, input logic [4:0] rs1,
                                            input logic [4:0] rs2, input logic [12:0] off);
    branch_op = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jal_op(input logic [4:0] rd, input logic [20:0] off);
    jal_op = {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  // Full-word write with AW and W together and bready held low for hold cycles
  task automatic axi_write(input logic [15:0] addr, input logic [31:0] data, input int hold);
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    @(posedge clk); #1;
    while (!awready) begin
      @(posedge clk); #1;
    end
    check("wready", 32'(wready), 32'd1); // AW and W accepted together
    @(posedge clk); #1; // Handshake edge passed
    awvalid = 1'b0;
    wvalid  = 1'b0;
    check("bvalid", 32'(bvalid), 32'd1);
    check("bresp", 32'(bresp), 32'd0);
    repeat (hold) begin
      @(posedge clk); #1;
      check("bvalid held", 32'(bvalid), 32'd1);
    end
    bready = 1'b1;
    @(posedge clk); #1;
    bready = 1'b0;
    check("bvalid after accept", 32'(bvalid), 32'd0);
  endtask

  task automatic axi_read(input logic [15:0] addr, input int hold, output logic [31:0] data);
    araddr  = addr;
    arvalid = 1'b1;
    @(posedge clk); #1;
    while (!arready) begin
      @(posedge clk); #1;
    end
    @(posedge clk); #1;
    arvalid = 1'b0;
    check("rvalid", 32'(rvalid), 32'd1);
    check("rresp", 32'(rresp), 32'd0);
    data = rdata;
    repeat (hold) begin
      @(posedge clk); #1;
      check("rvalid held", 32'(rvalid), 32'd1);
      check("rdata held", rdata, data); // Must not move under back-pressure
    end
    rready = 1'b1;
    @(posedge clk); #1;
    rready = 1'b0;
    check("rvalid after accept", 32'(rvalid), 32'd0);
  endtask

  // ISA reference model that stops on EBREAK with the PC in place
  task automatic run_model(input int len);
    logic [31:0] iw;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] res;
    logic [31:0] next;
    logic        wr;
    int          steps;
    bit          done;
    m_pc  = '0;
    steps = 0;
    done  = 1'b0;
    while (!done) begin
      if (steps > 1000 || int'(m_pc[31:2]) >= len) begin
        $display("Reference model ran off the end of the program");
        fail_stop();
      end
      iw    = prog[int'(m_pc[31:2])];
      a     = m_regs[iw[19:15]];
      b     = m_regs[iw[24:20]];
      imm_i = {{20{iw[31]}}, iw[31:20]};
      next  = m_pc + 32'd4;
      wr    = 1'b0;
      res   = '0;
      case (iw[6:0])
        7'b0110111: begin
          res = {iw[31:12], 12'h000};
          wr  = 1'b1;
        end
        7'b0010011: begin
          wr = 1'b1;
          case (iw[14:12])
            F_ADD:   res = a + imm_i;
            F_SLT:   res = ($signed(a) < $signed(imm_i)) ? 32'd1 : 32'd0;
            F_XOR:   res = a ^ imm_i;
            F_OR:    res = a | imm_i;
            F_AND:   res = a & imm_i;
            default: wr = 1'b0;
          endcase
        end
        7'b0110011: begin
          wr = 1'b1;
          case ({iw[31:25], iw[14:12]})
            {7'd0, F_ADD}:   res = a + b;
            {F7_SUB, F_ADD}: res = a - b;
            {7'd0, F_SLT}:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            {7'd0, F_XOR}:   res = a ^ b;
            {7'd0, F_OR}:    res = a | b;
            {7'd0, F_AND}:   res = a & b;
            default:         wr = 1'b0;
          endcase
        end
        7'b1100011: begin
          if ((iw[14:12] == 3'b000 && a == b) || (iw[14:12] == 3'b001 && a != b))
            next = m_pc + {{20{iw[31]}}, iw[7], iw[30:25], iw[11:8], 1'b0};
        end
        7'b1101111: begin
          res  = m_pc + 32'd4; // Link
          wr   = 1'b1;
          next = m_pc + {{12{iw[31]}}, iw[19:12], iw[20], iw[30:21], 1'b0};
        end
        default: begin
          if (iw == EBREAK) begin
            done = 1'b1;
            next = m_pc;
          end
        end
      endcase
      if (wr && iw[11:7] != 5'd0) m_regs[iw[11:7]] = res;
      m_pc  = next;
      steps = steps + 1;
    end
  endtask

  task automatic start_and_wait(input int hold);
    logic [31:0] st;
    axi_write(ADDR_CTRL, 32'd1, hold);
    do begin
      axi_read(ADDR_STATUS, 0, st);
    end while (!st[0]); // Watchdog bounds this poll
    check("status at halt", st, 32'd3);
  endtask

  task automatic run_program(input int len, input int hold);
    for (int i = 0; i < len; i++) axi_write(16'(i * 4), prog[i], hold);
    start_and_wait(hold);
    run_model(len);
  endtask

  task automatic compare_state(input int hold);
    logic [31:0] v;
    for (int i = 0; i < 32; i++) begin
      axi_read(16'(ADDR_REGS + i * 4), hold, v);
      check($sformatf("x%0d", i), v, m_regs[i]);
    end
    axi_read(ADDR_PC, hold, v);
    check("pc", v, m_pc);
  endtask

  task automatic expect_reg(input int idx, input logic [31:0] exp);
    logic [31:0] v;
    axi_read(16'(ADDR_REGS + idx * 4), 0, v);
    check($sformatf("x%0d", idx), v, exp);
  endtask

  task automatic reset_state_test();
    logic [31:0] v;
    axi_read(ADDR_STATUS, 0, v);
    check("status", v, 32'd0);
    axi_read(ADDR_PC, 0, v);
    check("pc", v, 32'd0);
    for (int i = 0; i < 32; i++) expect_reg(i, 32'd0);
  endtask

  task automatic alu_ops_test();
    prog[0]  = imm_op(F_ADD, 5'd1, 5'd0, 12'd100);
    prog[1]  = imm_op(F_ADD, 5'd2, 5'd0, -12'd7);
    prog[2]  = imm_op(F_AND, 5'd3, 5'd1, 12'h0f0);
    prog[3]  = imm_op(F_OR, 5'd4, 5'd2, 12'h055);
    prog[4]  = imm_op(F_XOR, 5'd5, 5'd1, -12'd1);
    prog[5]  = imm_op(F_SLT, 5'd6, 5'd2, 12'd5);   // -7 < 5
    prog[6]  = imm_op(F_SLT, 5'd7, 5'd1, -12'd3);
    prog[7]  = reg_op(7'd0, F_ADD, 5'd8, 5'd1, 5'd2);
    prog[8]  = reg_op(F7_SUB, F_ADD, 5'd9, 5'd2, 5'd1);
    prog[9]  = reg_op(7'd0, F_AND, 5'd10, 5'd1, 5'd2);
    prog[10] = reg_op(7'd0, F_OR, 5'd11, 5'd1, 5'd2);
    prog[11] = reg_op(7'd0, F_XOR, 5'd12, 5'd1, 5'd2);
    prog[12] = reg_op(7'd0, F_SLT, 5'd13, 5'd2, 5'd1);
    prog[13] = reg_op(7'd0, F_SLT, 5'd14, 5'd1, 5'd2);
    prog[14] = lui_op(5'd15, 20'habcde);
    prog[15] = reg_op(7'd0, F_ADD, 5'd16, 5'd15, 5'd1);
    prog[16] = imm_op(F_ADD, 5'd0, 5'd1, 12'd5);    // Targets x0
    prog[17] = reg_op(7'd0, F_ADD, 5'd0, 5'd1, 5'd2);
    prog[18] = EBREAK;
    run_program(19, 0);
    compare_state(0);
    expect_reg(0, 32'd0);
    expect_reg(8, 32'd93);
    expect_reg(15, 32'habcde000);
  endtask

  task automatic control_flow_test();
    prog[0]  = imm_op(F_ADD, 5'd1, 5'd0, 12'd5);
    prog[1]  = imm_op(F_ADD, 5'd2, 5'd0, 12'd5);
    prog[2]  = imm_op(F_ADD, 5'd3, 5'd0, 12'd9);
    prog[3]  = branch_op(3'b000, 5'd1, 5'd2, 13'd8);  // BEQ taken
    prog[4]  = imm_op(F_ADD, 5'd20, 5'd0, 12'd1);
    prog[5]  = branch_op(3'b001, 5'd1, 5'd2, 13'd8);  // BNE not taken
    prog[6]  = imm_op(F_ADD, 5'd21, 5'd0, 12'd2);
    prog[7]  = branch_op(3'b001, 5'd1, 5'd3, 13'd8);  // BNE taken
    prog[8]  = imm_op(F_ADD, 5'd22, 5'd0, 12'd3);
    prog[9]  = branch_op(3'b000, 5'd1, 5'd3, 13'd8);  // BEQ not taken
    prog[10] = imm_op(F_ADD, 5'd23, 5'd0, 12'd4);
    prog[11] = jal_op(5'd24, 21'd12);
    prog[12] = imm_op(F_ADD, 5'd25, 5'd0, 12'd5);
    prog[13] = imm_op(F_ADD, 5'd26, 5'd0, 12'd6);
    prog[14] = imm_op(F_ADD, 5'd27, 5'd0, 12'd3);
    prog[15] = imm_op(F_ADD, 5'd27, 5'd27, -12'd1);  // Loop body
    prog[16] = imm_op(F_ADD, 5'd28, 5'd28, 12'd2);
    prog[17] = branch_op(3'b001, 5'd27, 5'd0, -13'd8); // Back edge
    prog[18] = EBREAK;
    run_program(19, 0);
    compare_state(0);
    expect_reg(20, 32'd0);
    expect_reg(21, 32'd2);
    expect_reg(22, 32'd0);
    expect_reg(23, 32'd4);
    expect_reg(24, 32'd48); // Return address after the JAL
    expect_reg(25, 32'd0);
    expect_reg(26, 32'd0);
    expect_reg(28, 32'd6);
    check("halt pc", m_pc, 32'd72);
  endtask

  task automatic random_program_test();
    int         kind;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    for (int i = 0; i < 40; i++) begin
      kind = int'(take_bits(3)) % 5;
      rd   = 5'(take_bits(5));
      rs1  = 5'(take_bits(5));
      rs2  = 5'(take_bits(5));
      case (kind)
        0:       prog[i] = imm_op(F_ADD, rd, rs1, 12'(take_bits(12)));
        1:       prog[i] = reg_op(7'd0, F_ADD, rd, rs1, rs2);
        2:       prog[i] = reg_op(F7_SUB, F_ADD, rd, rs1, rs2);
        3:       prog[i] = reg_op(7'd0, F_XOR, rd, rs1, rs2);
        default: prog[i] = lui_op(rd, 20'(take_bits(20)));
      endcase
    end
    prog[40] = EBREAK;
    run_program(41, 0);
    compare_state(0);
    check("halt pc", m_pc, 32'd160);
  endtask

  task automatic restart_backpressure_test();
    logic [31:0] st;
    axi_write(ADDR_CTRL, 32'd0, 5); // Clears run only
    axi_read(ADDR_STATUS, 5, st);
    check("status after stop", st, 32'd1);
    prog[0] = imm_op(F_ADD, 5'd5, 5'd0, 12'd7); // Only x0-based sources
    prog[1] = imm_op(F_ADD, 5'd6, 5'd0, -12'd3);
    prog[2] = reg_op(7'd0, F_ADD, 5'd7, 5'd5, 5'd6);
    prog[3] = reg_op(F7_SUB, F_ADD, 5'd8, 5'd6, 5'd5);
    prog[4] = reg_op(7'd0, F_SLT, 5'd9, 5'd6, 5'd5);
    prog[5] = imm_op(F_ADD, 5'd10, 5'd10, 12'd1); // Counts passes
    prog[6] = EBREAK;
    run_program(7, 5);
    compare_state(5);
    start_and_wait(5); // Rerun from zero bumps x10 once more
    run_model(7);
    compare_state(5);
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    fail_stop();
  end

  initial begin
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    for (int i = 0; i < 32; i++) m_regs[i] = '0;
    m_pc = '0;
    @(negedge rst);
    @(posedge clk); #1;
    reset_state_test();
    alu_ops_test();
    control_flow_test();
    random_program_test();
    restart_backpressure_test();
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

//--- vlog.f
logic/rv_pkg.sv
logic/exec_if.sv
logic/pc_fetch.sv
logic/decode_ctrl.sv
logic/reg_file.sv
logic/execute_unit.sv
logic/host_axil.sv
logic/rv_core_top.sv
test/tb_clock.sv
test/rv_core_props.sv
test/tb_rv_core.sv
